/* Bender.yml */
package:
  name: axi_wr_master

sources:
  - files:
      - verilog/axi_wr_pkg.sv
      - verilog/slot_picker.sv
      - verilog/wr_order_fifo.sv
      - verilog/burst_addr_calc.sv
      - verilog/wr_slot_table.sv
      - verilog/wr_data_sender.sv
      - verilog/axi_wr_master.sv
  - target: test
    files:
      - tb/tb_axi_wr_master.sv

/* sources.f */
verilog/axi_wr_pkg.sv
verilog/slot_picker.sv
verilog/wr_order_fifo.sv
verilog/burst_addr_calc.sv
verilog/wr_slot_table.sv
verilog/wr_data_sender.sv
verilog/axi_wr_master.sv
tb/tb_axi_wr_master.sv

/* tb/tb_axi_wr_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_master
    import axi_wr_pkg::*;
();

    localparam int OST_DEPTH  = 8;
    localparam int NUM_REQS   = 16;
    localparam int CLK_HALF   = 50;
    localparam int RST_CYCLES = 8;
    localparam int WAIT_LIMIT = 2000;

    logic              clk;
    logic              rst_n;
    logic              wr_en;
    logic              wr_req_finish;
    logic              resp_error;
    id_t               awid;
    addr_t             awaddr;
    len_t              awlen;
    logic [SIZE_W-1:0] awsize;
    burst_t            awburst;
    user_t             awuser;
    logic              awvalid;
    logic              awready;
    data_t             wdata;
    strb_t             wstrb;
    user_t             wuser;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    id_t               bid;
    resp_t             bresp;
    logic              bvalid;
    logic              bready;

    // Expected values per request number
    addr_t  exp_addr  [NUM_REQS];
    burst_t exp_burst [NUM_REQS];
    addr_t  exp_beat  [NUM_REQS][BURST_BEATS];
    resp_t  exp_resp  [NUM_REQS];

    // Slave model state
    int                  w_order [$];
    int                  b_queue [$];
    int                  w_beat;
    int                  b_wait;
    logic                err_seen;
    logic [NUM_REQS-1:0] aw_seen;
    logic [NUM_REQS-1:0] b_done;
    logic                aw_stall;
    addr_t               prev_awaddr;
    id_t                 prev_awid;
    burst_t              prev_awburst;
    user_t               prev_awuser;
    logic                w_stall;
    data_t               prev_wdata;
    logic                prev_wlast;

    axi_wr_master #(
        .OST_DEPTH (OST_DEPTH),
        .NUM_REQS  (NUM_REQS)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_req_finish (wr_req_finish),
        .resp_error    (resp_error),
        .awid          (awid),
        .awaddr        (awaddr),
        .awlen         (awlen),
        .awsize        (awsize),
        .awburst       (awburst),
        .awuser        (awuser),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wuser         (wuser),
        .wlast         (wlast),
        .wvalid        (wvalid),
        .wready        (wready),
        .bid           (bid),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    always #CLK_HALF clk = ~clk;

    // --------------------------------------------------------------------------
    // Reporting
    // --------------------------------------------------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    // --------------------------------------------------------------------------
    // Expected table
    // --------------------------------------------------------------------------
    // WRAP at 0x24 gives 24 28 2C 20
    function automatic addr_t expected_beat_addr(input addr_t start, input burst_t kind,
                                                 input int beat);
        addr_t step;
        addr_t result;
        step = addr_t'(beat * BEAT_BYTES);
        case (kind)
            BURST_FIXED: begin
                result = start;
            end
            BURST_WRAP: begin
                result = (start / 16) * 16 + ((start + step) % 16);
            end
            default: begin
                result = (start / BEAT_BYTES) * BEAT_BYTES + step;
            end
        endcase
        return result;
    endfunction

    function automatic data_t expected_wdata(input int n, input int beat);
        return (data_t'(id_t'(n)) << ADDR_W) | data_t'(exp_beat[n][beat]);
    endfunction

    task automatic build_table();
        for (int n = 0; n < NUM_REQS; n++) begin
            case (n % 4)
                0: begin
                    exp_addr[n]  = addr_t'('h00);
                    exp_burst[n] = BURST_INCR;
                end
                1: begin
                    exp_addr[n]  = addr_t'(n * 'h10);
                    exp_burst[n] = BURST_INCR;
                end
                2: begin
                    exp_addr[n]  = addr_t'('h24);
                    exp_burst[n] = BURST_WRAP;
                end
                default: begin
                    exp_addr[n]  = addr_t'('h30);
                    exp_burst[n] = BURST_FIXED;
                end
            endcase
            for (int b = 0; b < BURST_BEATS; b++) begin
                exp_beat[n][b] = expected_beat_addr(exp_addr[n], exp_burst[n], b);
            end
            exp_resp[n] = (n == 5) ? RESP_SLVERR : RESP_OKAY;
        end
    endtask

    // --------------------------------------------------------------------------
    // Slave model and bus checks
    // --------------------------------------------------------------------------
    always @(posedge clk) begin : slave_model
        int n;
        if (rst_n) begin
            check_val(resp_error, err_seen, "resp_error flag");

            // AW payload must hold while stalled
            if (aw_stall) begin
                check_val(awvalid, 1'b1, "awvalid dropped before awready");
                check_val(awaddr, prev_awaddr, "awaddr changed under back-pressure");
                check_val(awid, prev_awid, "awid changed under back-pressure");
                check_val(awburst, prev_awburst, "awburst changed under back-pressure");
                check_val(awuser, prev_awuser, "awuser changed under back-pressure");
            end
            if (awvalid && awready) begin
                n = int'(awid);
                check_val(aw_seen[n], 1'b0, $sformatf("awid %0d issued twice", n));
                check_val(awlen, len_t'(3), $sformatf("awlen of request %0d", n));
                check_val(awsize, 3'd2, $sformatf("awsize of request %0d", n));
                check_val(awaddr, exp_addr[n], $sformatf("awaddr of request %0d", n));
                check_val(awburst, exp_burst[n], $sformatf("awburst of request %0d", n));
                check_val(awuser, user_t'(n), $sformatf("awuser of request %0d", n));
                aw_seen[n] = 1'b1;
                w_order.push_back(n);
            end

            if (w_stall) begin
                check_val(wvalid, 1'b1, "wvalid dropped before wready");
                check_val(wdata, prev_wdata, "wdata changed under back-pressure");
                check_val(wlast, prev_wlast, "wlast changed under back-pressure");
            end
            if (wvalid && wready) begin
                check_val(w_order.size() > 0, 1'b1, "W beat with no AW outstanding");
                n = w_order[0];
                check_val(wdata, expected_wdata(n, w_beat),
                          $sformatf("wdata of request %0d beat %0d", n, w_beat));
                check_val(wstrb, strb_t'('1), $sformatf("wstrb of request %0d", n));
                check_val(wuser, user_t'(n), $sformatf("wuser of request %0d", n));
                check_val(wlast, w_beat == BURST_BEATS - 1,
                          $sformatf("wlast of request %0d beat %0d", n, w_beat));
                if (w_beat == BURST_BEATS - 1) begin
                    w_beat = 0;
                    void'(w_order.pop_front());
                    b_queue.push_back(n);
                end else begin
                    w_beat++;
                end
            end

            if (bvalid) begin
                check_val(bready, 1'b1, "bready low while bvalid");
                b_done[bid] = 1'b1;
                if ((bresp == RESP_SLVERR) || (bresp == RESP_DECERR)) begin
                    err_seen = 1'b1;
                end
            end

            // Responses go out in wlast order after a random gap
            bvalid <= 1'b0;
            if (b_queue.size() > 0) begin
                if (b_wait == 0) begin
                    n = b_queue.pop_front();
                    bid    <= id_t'(n);
                    bresp  <= exp_resp[n];
                    bvalid <= 1'b1;
                    b_wait = $urandom_range(0, 4);
                end else begin
                    b_wait--;
                end
            end
            awready <= ($urandom_range(0, 1) == 1);
            wready  <= ($urandom_range(0, 3) != 0);

            aw_stall     = awvalid && !awready;
            prev_awaddr  = awaddr;
            prev_awid    = awid;
            prev_awburst = awburst;
            prev_awuser  = awuser;
            w_stall      = wvalid && !wready;
            prev_wdata   = wdata;
            prev_wlast   = wlast;
        end
    end

    // --------------------------------------------------------------------------
    // Main sequence
    // --------------------------------------------------------------------------
    initial begin
        int cycles;
        void'($urandom(32'hf6d8));
        clk      = 1'b0;
        rst_n    = 1'b0;
        wr_en    = 1'b0;
        awready  = 1'b0;
        wready   = 1'b0;
        bvalid   = 1'b0;
        bid      = '0;
        bresp    = RESP_OKAY;
        w_beat   = 0;
        b_wait   = 0;
        err_seen = 1'b0;
        aw_seen  = '0;
        b_done   = '0;
        aw_stall = 1'b0;
        w_stall  = 1'b0;
        build_table();

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val(awvalid, 1'b0, "awvalid after reset");
        check_val(wvalid, 1'b0, "wvalid after reset");
        check_val(wlast, 1'b0, "wlast after reset");
        check_val(wr_req_finish, 1'b0, "wr_req_finish after reset");
        check_val(resp_error, 1'b0, "resp_error after reset");

        // Request enable toggles randomly until each request has its response
        for (int n = 0; n < NUM_REQS; n++) begin
            cycles = 0;
            while (!b_done[n]) begin
                @(posedge clk);
                wr_en <= ($urandom_range(0, 7) != 0);
                @(negedge clk);
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    stop_run($sformatf("Timeout while waiting for the response to request %0d",
                                       n));
                end
            end
        end

        @(posedge clk);
        wr_en <= 1'b0;
        @(negedge clk);
        check_val(wr_req_finish, 1'b1, "wr_req_finish at end");
        check_val(resp_error, 1'b1, "resp_error at end");
        check_val(awvalid, 1'b0, "awvalid at end");
        check_val(wvalid, 1'b0, "wvalid at end");
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/axi_wr_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_master
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH = 8,
    parameter int NUM_REQS  = 16
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    output logic              wr_req_finish,
    output logic              resp_error,

    // AW channel
    output id_t               awid,
    output addr_t             awaddr,
    output len_t              awlen,
    output logic [SIZE_W-1:0] awsize,
    output burst_t            awburst,
    output user_t             awuser,
    output logic              awvalid,
    input  logic              awready,

    // W channel
    output data_t             wdata,
    output strb_t             wstrb,
    output user_t             wuser,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,

    // B channel
    input  id_t               bid,
    input  resp_t             bresp,
    input  logic              bvalid,
    output logic              bready
);

    localparam int SLOT_W = $clog2(OST_DEPTH);

    logic              aw_done;
    logic [SLOT_W-1:0] aw_slot;
    logic              fifo_empty;
    logic              fifo_pop;
    logic [SLOT_W-1:0] head_slot;
    logic [SLOT_W-1:0] rd_slot;
    addr_t             rd_addr;
    burst_t            rd_burst;
    id_t               rd_id;
    user_t             rd_user;

    // ------------------------------------------------------------------------
    // Slot table with AW and B channels
    // ------------------------------------------------------------------------
    wr_slot_table #(
        .OST_DEPTH (OST_DEPTH),
        .NUM_REQS  (NUM_REQS)
    ) u_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_req_finish (wr_req_finish),
        .resp_error    (resp_error),
        .awid          (awid),
        .awaddr        (awaddr),
        .awlen         (awlen),
        .awsize        (awsize),
        .awburst       (awburst),
        .awuser        (awuser),
        .awvalid       (awvalid),
        .awready       (awready),
        .aw_done       (aw_done),
        .aw_slot       (aw_slot),
        .rd_slot       (rd_slot),
        .rd_addr       (rd_addr),
        .rd_burst      (rd_burst),
        .rd_id         (rd_id),
        .rd_user       (rd_user),
        .bid           (bid),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready)
    );

    // AW order for the W channel
    wr_order_fifo #(.DEPTH(OST_DEPTH)) u_order (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (aw_done),
        .push_slot (aw_slot),
        .pop       (fifo_pop),
        .empty     (fifo_empty),
        .head_slot (head_slot)
    );

    wr_data_sender #(.OST_DEPTH(OST_DEPTH)) u_sender (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .head_slot  (head_slot),
        .fifo_pop   (fifo_pop),
        .rd_slot    (rd_slot),
        .rd_addr    (rd_addr),
        .rd_burst   (rd_burst),
        .rd_id      (rd_id),
        .rd_user    (rd_user),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wuser      (wuser),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wready     (wready)
    );

endmodule

`default_nettype wire

/* verilog/axi_wr_pkg.sv */
`default_nettype none

package axi_wr_pkg;

    // ------------------------------------------------------------------------
    // AXI field widths
    // ------------------------------------------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned ID_W   = 4;
    localparam int unsigned LEN_W  = 8;
    localparam int unsigned SIZE_W = 3;
    localparam int unsigned USER_W = 8;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [DATA_W/8-1:0] strb_t;
    typedef logic [ID_W-1:0]     id_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [USER_W-1:0]   user_t;

    // Burst and response encodings as on the bus
    typedef enum logic [1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1,
        BURST_WRAP  = 2'd2
    } burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_EXOKAY = 2'd1,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_t;

    // ------------------------------------------------------------------------
    // Burst shape shared by every request
    // ------------------------------------------------------------------------
    localparam int unsigned BEAT_BYTES  = 4;
    localparam logic [SIZE_W-1:0] BEAT_SIZE = SIZE_W'($clog2(BEAT_BYTES));
    localparam int unsigned BURST_BEATS = 4;
    localparam len_t BURST_LEN = len_t'(BURST_BEATS - 1);

endpackage

`default_nettype wire

/* verilog/burst_addr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_addr_calc
    import axi_wr_pkg::*;
(
    input  addr_t      start_addr,
    input  burst_t     burst,
    input  logic [1:0] beat,
    output addr_t      addr
);

    // One full burst of bytes is also the wrap window
    localparam int unsigned WRAP_BYTES = BURST_BEATS * BEAT_BYTES;

    localparam addr_t BEAT_MASK = addr_t'(BEAT_BYTES - 1);
    localparam addr_t WRAP_MASK = addr_t'(WRAP_BYTES - 1);

    addr_t offset;
    addr_t aligned;
    addr_t wrap_base;
    addr_t wrap_low;

    // ------------------------------------------------------------------------
    // Address terms
    // ------------------------------------------------------------------------
    assign offset  = addr_t'(beat) * addr_t'(BEAT_BYTES);
    assign aligned = start_addr & ~BEAT_MASK;

    // WRAP keeps the bits above the window and rolls the low part
    assign wrap_base = start_addr & ~WRAP_MASK;
    assign wrap_low  = (start_addr + offset) & WRAP_MASK;

    // ------------------------------------------------------------------------
    // Select by burst type
    // ------------------------------------------------------------------------
    always_comb begin
        case (burst)
            BURST_FIXED: begin
                addr = start_addr;
            end
            BURST_INCR: begin
                addr = aligned + offset;
            end
            BURST_WRAP: begin
                addr = wrap_base | wrap_low;
            end
            default: begin
                // Reserved encoding behaves like FIXED
                addr = start_addr;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/slot_picker.sv */
`timescale 1ns/1ps
`default_nettype none

// Lowest set bit wins
module slot_picker #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req,
    output logic                     any,
    output logic [$clog2(WIDTH)-1:0] index
);

    localparam int IDX_W = $clog2(WIDTH);

    assign any = |req;

    // Scan from the top so the lowest request overwrites last
    always_comb begin
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                index = IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/wr_data_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_data_sender
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Order FIFO
    input  logic                         fifo_empty,
    input  logic [$clog2(OST_DEPTH)-1:0] head_slot,
    output logic                         fifo_pop,

    // Slot table lookup
    output logic [$clog2(OST_DEPTH)-1:0] rd_slot,
    input  addr_t                        rd_addr,
    input  burst_t                       rd_burst,
    input  id_t                          rd_id,
    input  user_t                        rd_user,

    // W channel
    output data_t                        wdata,
    output strb_t                        wstrb,
    output user_t                        wuser,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready
);

    localparam logic [1:0] LAST_BEAT = 2'(BURST_LEN);

    logic [1:0] beat_cnt;
    logic       w_hs;
    addr_t      beat_addr;

    burst_addr_calc u_addr (
        .start_addr (rd_addr),
        .burst      (rd_burst),
        .beat       (beat_cnt),
        .addr       (beat_addr)
    );

    // Head slot owns the W channel until its last beat
    assign rd_slot  = head_slot;
    assign wvalid   = !fifo_empty;
    assign wlast    = wvalid && (beat_cnt == LAST_BEAT);
    assign w_hs     = wvalid && wready;
    assign fifo_pop = w_hs && wlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= wlast ? 2'd0 : beat_cnt + 1'b1;
        end
    end

    // Beat payload is the ID stacked on the beat address
    assign wdata = data_t'({rd_id, beat_addr});
    assign wstrb = '1;
    assign wuser = rd_user;

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> $stable(wdata) && $stable(wlast));

endmodule

`default_nettype wire

/* verilog/wr_order_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_order_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  logic [$clog2(DEPTH)-1:0] push_slot,
    input  logic                     pop,
    output logic                     empty,
    output logic [$clog2(DEPTH)-1:0] head_slot
);

    localparam int SLOT_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);

    logic [SLOT_W-1:0] mem [DEPTH];
    logic [SLOT_W-1:0] wr_ptr;
    logic [SLOT_W-1:0] rd_ptr;
    logic [SLOT_W-1:0] rd_next;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  count_next;

    function automatic logic [SLOT_W-1:0] ptr_inc(input logic [SLOT_W-1:0] ptr);
        if (ptr == SLOT_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign rd_next    = pop ? ptr_inc(rd_ptr) : rd_ptr;
    assign count_next = count + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_slot;
        end
    end

    // Head comes straight from push_slot when the new entry lands at the read side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            empty     <= 1'b1;
            head_slot <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            rd_ptr    <= rd_next;
            count     <= count_next;
            empty     <= (count_next == '0);
            head_slot <= (push && (wr_ptr == rd_next)) ? push_slot : mem[rd_next];
        end
    end

    no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != CNT_W'(DEPTH)));

    no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

/* verilog/wr_slot_table.sv */
`timescale 1ns/1ps
`default_nettype none

module wr_slot_table
    import axi_wr_pkg::*;
#(
    parameter int OST_DEPTH = 8,
    parameter int NUM_REQS  = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    output logic                         wr_req_finish,
    output logic                         resp_error,

    // AW channel
    output id_t                          awid,
    output addr_t                        awaddr,
    output len_t                         awlen,
    output logic [SIZE_W-1:0]            awsize,
    output burst_t                       awburst,
    output user_t                        awuser,
    output logic                         awvalid,
    input  logic                         awready,
    output logic                         aw_done,
    output logic [$clog2(OST_DEPTH)-1:0] aw_slot,

    // Read port for the W side
    input  logic [$clog2(OST_DEPTH)-1:0] rd_slot,
    output addr_t                        rd_addr,
    output burst_t                       rd_burst,
    output id_t                          rd_id,
    output user_t                        rd_user,

    // B channel
    input  id_t                          bid,
    input  resp_t                        bresp,
    input  logic                         bvalid,
    output logic                         bready
);

    localparam int SLOT_W = $clog2(OST_DEPTH);
    localparam int CNT_W  = $clog2(NUM_REQS + 1);

    if (NUM_REQS > (1 << ID_W)) begin : g_id_check
        $error("NUM_REQS larger than the AXI ID space");
    end

    // Per slot state
    logic [OST_DEPTH-1:0] busy;
    logic [OST_DEPTH-1:0] aw_pend;
    logic [OST_DEPTH-1:0] aw_sent;

    // Per slot request payload
    id_t    slot_id    [OST_DEPTH];
    addr_t  slot_addr  [OST_DEPTH];
    burst_t slot_burst [OST_DEPTH];
    user_t  slot_user  [OST_DEPTH];

    logic              free_any;
    logic [SLOT_W-1:0] free_idx;
    logic              pend_any;
    logic [SLOT_W-1:0] pend_idx;

    logic [CNT_W-1:0]     req_cnt;
    logic                 alloc_ok;
    logic                 alloc;
    logic                 aw_hs;
    logic                 b_hs;
    logic [OST_DEPTH-1:0] b_hit;
    logic [OST_DEPTH-1:0] alloc_mask;
    logic [OST_DEPTH-1:0] aw_mask;
    logic [OST_DEPTH-1:0] free_mask;
    addr_t                new_addr;
    burst_t               new_burst;

    // ------------------------------------------------------------------------
    // Slot selection
    // ------------------------------------------------------------------------
    slot_picker #(.WIDTH(OST_DEPTH)) u_free_pick (
        .req   (~busy),
        .any   (free_any),
        .index (free_idx)
    );

    slot_picker #(.WIDTH(OST_DEPTH)) u_pend_pick (
        .req   (aw_pend),
        .any   (pend_any),
        .index (pend_idx)
    );

    // A new slot below a stalled AW would steal the AW selection
    assign alloc_ok = !pend_any || aw_hs || (free_idx > pend_idx);
    assign alloc    = wr_en && free_any && alloc_ok && (req_cnt < CNT_W'(NUM_REQS));
    assign aw_hs    = awvalid && awready;
    assign b_hs     = bvalid && bready;

    always_comb begin
        for (int i = 0; i < OST_DEPTH; i++) begin
            b_hit[i] = busy[i] && aw_sent[i] && (slot_id[i] == bid);
        end
    end

    assign alloc_mask = OST_DEPTH'(alloc) << free_idx;
    assign aw_mask    = OST_DEPTH'(aw_hs) << pend_idx;
    assign free_mask  = b_hs ? b_hit : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= '0;
            aw_pend <= '0;
            aw_sent <= '0;
            req_cnt <= '0;
        end else begin
            busy    <= (busy | alloc_mask) & ~free_mask;
            aw_pend <= (aw_pend | alloc_mask) & ~aw_mask;
            aw_sent <= (aw_sent | aw_mask) & ~free_mask;
            if (alloc) begin
                req_cnt <= req_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Request pattern picked by the low bits of the count
    // ------------------------------------------------------------------------
    always_comb begin
        case (req_cnt[1:0])
            2'd0: begin
                new_addr  = '0;
                new_burst = BURST_INCR;
            end
            2'd1: begin
                new_addr  = addr_t'(req_cnt) << 4;
                new_burst = BURST_INCR;
            end
            2'd2: begin
                new_addr  = addr_t'('h24);
                new_burst = BURST_WRAP;
            end
            default: begin
                new_addr  = addr_t'('h30);
                new_burst = BURST_FIXED;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_id[free_idx]    <= id_t'(req_cnt);
            slot_addr[free_idx]  <= new_addr;
            slot_burst[free_idx] <= new_burst;
            slot_user[free_idx]  <= user_t'(req_cnt);
        end
    end

    // Sticky error over all responses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_error <= 1'b0;
        end else if (b_hs && ((bresp == RESP_SLVERR) || (bresp == RESP_DECERR))) begin
            resp_error <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    assign wr_req_finish = (req_cnt == CNT_W'(NUM_REQS));

    assign awvalid = pend_any;
    assign awid    = slot_id[pend_idx];
    assign awaddr  = slot_addr[pend_idx];
    assign awlen   = BURST_LEN;
    assign awsize  = BEAT_SIZE;
    assign awburst = slot_burst[pend_idx];
    assign awuser  = slot_user[pend_idx];
    assign aw_done = aw_hs;
    assign aw_slot = pend_idx;

    assign rd_addr  = slot_addr[rd_slot];
    assign rd_burst = slot_burst[rd_slot];
    assign rd_id    = slot_id[rd_slot];
    assign rd_user  = slot_user[rd_slot];

    assign bready = 1'b1;

    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

    b_one_slot: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> $onehot(b_hit));

endmodule

`default_nettype wire
